//--- Makefile
# Verilator build and run for the machine-mode privilege unit

VERILATOR ?= verilator
TOP       ?= tb_priv_unit
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := $(wildcard design/*.svh)
DATA := test/priv_testdata.txt

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Runs from the project root so the vector file path resolves
run: $(BIN) $(DATA)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/csr_prv_if.sv
// Register values and update requests between the CSR file and the trap controller
`timescale 1ns/1ps

interface csr_prv_if;
  import machine_mode_types_pkg::*;

  // Current register state, driven by the CSR file
  mstatus_t mstatus;
  mie_t     mie;
  mip_t     mip;
  word_t    mepc;
  word_t    mtvec;
  mcause_t  mcause;

  // Update pulses, each takes effect at the next edge
  logic     mstatus_ie_rup;
  logic     mip_msip_rup;
  logic     mepc_rup;
  logic     mcause_rup;
  logic     mbadaddr_rup;

  // Values loaded with the pulses
  logic     mstatus_ie_next;
  logic     mip_msip_next;
  word_t    mepc_next;
  mcause_t  mcause_next;
  word_t    mbadaddr_next;

  modport csr (
    output mstatus, mie, mip, mepc, mtvec, mcause,
    input  mstatus_ie_rup, mip_msip_rup, mepc_rup, mcause_rup, mbadaddr_rup,
    input  mstatus_ie_next, mip_msip_next, mepc_next, mcause_next, mbadaddr_next
  );

  modport prv (
    input  mstatus, mie, mip, mepc, mtvec, mcause,
    output mstatus_ie_rup, mip_msip_rup, mepc_rup, mcause_rup, mbadaddr_rup,
    output mstatus_ie_next, mip_msip_next, mepc_next, mcause_next, mbadaddr_next
  );

endinterface

//--- design/csr_rfile.sv
// Machine-mode CSR storage with read mux and read-modify-write, instantiated in priv_unit
`timescale 1ns/1ps
`include "prv_consts.svh"

module csr_rfile (
  input  logic                          CLK,
  input  logic                          nRST,
  prv_pipeline_if.csr                   pipe,
  csr_prv_if.csr                        prv,
  input  logic                          fromhost_we,
  input  machine_mode_types_pkg::word_t fromhost_data,
  output machine_mode_types_pkg::word_t tohost
);
  import machine_mode_types_pkg::*;

  // Writable state, only the bits that can change
  logic     mstatus_ie;
  logic     mie_msie;
  logic     mip_msip;
  word_t    mscratch;
  word_t    mepc;
  mcause_t  mcause;
  word_t    mbadaddr;
  word_t    mtohost;
  word_t    mfromhost;

  // Full register views
  mcpuid_t  mcpuid;
  mstatus_t mstatus;
  mie_t     mie;
  mip_t     mip;
  word_t    mtvec;

  // Read-modify-write path
  logic     valid_addr;
  logic     wr_en;
  word_t    rup_data;
  mstatus_t rup_status;

  // RV32I, implementation and hart id are zero
  assign mcpuid.base       = `MCPUID_BASE_RV32;
  assign mcpuid.zero       = '0;
  assign mcpuid.extensions = `MCPUID_EXT_I;

  assign mtvec = `MTVEC_ADDR;

  // Machine mode only, no FPU, no translation
  always_comb begin
    mstatus      = '0;
    mstatus.prv  = `PRV_MODE_M;
    mstatus.prv1 = `PRV_MODE_M;
    mstatus.prv2 = `PRV_MODE_M;
    mstatus.prv3 = `PRV_MODE_M;
    mstatus.ie   = mstatus_ie;
  end

  // Only the software interrupt exists, timer bits stay zero
  always_comb begin
    mie      = '0;
    mie.msie = mie_msie;
    mip      = '0;
    mip.msip = mip_msip;
  end

  // Read mux
  always_comb begin
    valid_addr = 1'b1;
    case (pipe.addr)
      CSR_MCPUID    : pipe.rdata = mcpuid;
      CSR_MIMPID    : pipe.rdata = '0;
      CSR_MHARTID   : pipe.rdata = '0;
      CSR_MSTATUS   : pipe.rdata = mstatus;
      CSR_MTVEC     : pipe.rdata = mtvec;
      CSR_MTDELEG   : pipe.rdata = '0;
      CSR_MIE       : pipe.rdata = mie;
      CSR_MSCRATCH  : pipe.rdata = mscratch;
      CSR_MEPC      : pipe.rdata = mepc;
      CSR_MCAUSE    : pipe.rdata = mcause;
      CSR_MBADADDR  : pipe.rdata = mbadaddr;
      CSR_MIP       : pipe.rdata = mip;
      // Timers and protection exist but read zero
      CSR_MTIMECMP,
      CSR_MTIME,
      CSR_MTIMEH,
      CSR_HTIMEW,
      CSR_HTIMEHW,
      CSR_MBASE,
      CSR_MBOUND,
      CSR_MIBASE,
      CSR_MIBOUND,
      CSR_MDBASE,
      CSR_MDBOUND   : pipe.rdata = '0;
      CSR_MTOHOST   : pipe.rdata = mtohost;
      CSR_MFROMHOST : pipe.rdata = mfromhost;
      default : begin
        valid_addr = 1'b0;
        pipe.rdata = '0;
      end
    endcase
  end

  // Flag only a real access, an idle bus never traps
  assign wr_en            = (pipe.op != CSR_NONE);
  assign pipe.invalid_csr = wr_en & ~valid_addr;

  // New value from the old one and wdata
  always_comb begin
    case (pipe.op)
      CSR_SWAP : rup_data = pipe.wdata;
      CSR_SET  : rup_data = pipe.rdata | pipe.wdata;
      CSR_CLR  : rup_data = pipe.rdata & ~pipe.wdata;
      default  : rup_data = pipe.rdata;
    endcase
  end

  assign rup_status = mstatus_t'(rup_data);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_ie <= 1'b1;
      mie_msie   <= 1'b0;
      mip_msip   <= 1'b0;
      mscratch   <= '0;
      mepc       <= '0;
      mcause     <= '0;
      mbadaddr   <= '0;
      mtohost    <= '0;
      mfromhost  <= '0;
    end else begin
      // Pipeline write beats a trap update
      if (wr_en && pipe.addr == CSR_MSTATUS) begin
        mstatus_ie <= rup_status.ie;
      end else if (prv.mstatus_ie_rup) begin
        mstatus_ie <= prv.mstatus_ie_next;
      end
      if (wr_en && pipe.addr == CSR_MEPC) begin
        mepc <= rup_data;
      end else if (prv.mepc_rup) begin
        mepc <= prv.mepc_next;
      end
      if (wr_en && pipe.addr == CSR_MIE) begin
        mie_msie <= rup_data[`MSIP_BIT];
      end
      if (wr_en && pipe.addr == CSR_MSCRATCH) begin
        mscratch <= rup_data;
      end
      if (wr_en && pipe.addr == CSR_MTOHOST) begin
        mtohost <= rup_data;
      end
      // Trap controller only
      if (prv.mip_msip_rup) begin
        mip_msip <= prv.mip_msip_next;
      end
      if (prv.mcause_rup) begin
        mcause <= prv.mcause_next;
      end
      if (prv.mbadaddr_rup) begin
        mbadaddr <= prv.mbadaddr_next;
      end
      // Host side
      if (fromhost_we) begin
        mfromhost <= fromhost_data;
      end
    end
  end

  // State seen by the trap controller
  assign prv.mstatus = mstatus;
  assign prv.mie     = mie;
  assign prv.mip     = mip;
  assign prv.mepc    = mepc;
  assign prv.mtvec   = mtvec;
  assign prv.mcause  = mcause;

  assign tohost = mtohost;

endmodule

//--- design/machine_mode_types_pkg.sv
// Types shared by the machine-mode privilege unit, imported by every design file
package machine_mode_types_pkg;

  // Data word of the RV32 core
  typedef logic [31:0] word_t;

  // CSR addresses of the older privileged spec
  typedef enum logic [11:0] {
    // Machine information
    CSR_MCPUID    = 12'hF00,
    CSR_MIMPID    = 12'hF01,
    CSR_MHARTID   = 12'hF10,
    // Trap setup
    CSR_MSTATUS   = 12'h300,
    CSR_MTVEC     = 12'h301,
    CSR_MTDELEG   = 12'h302,
    CSR_MIE       = 12'h304,
    CSR_MTIMECMP  = 12'h321,
    // Trap handling
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MBADADDR  = 12'h343,
    CSR_MIP       = 12'h344,
    // Protection, not implemented and reads zero
    CSR_MBASE     = 12'h380,
    CSR_MBOUND    = 12'h381,
    CSR_MIBASE    = 12'h382,
    CSR_MIBOUND   = 12'h383,
    CSR_MDBASE    = 12'h384,
    CSR_MDBOUND   = 12'h385,
    // Timers, read zero
    CSR_MTIME     = 12'h701,
    CSR_MTIMEH    = 12'h741,
    CSR_HTIMEW    = 12'hB01,
    CSR_HTIMEHW   = 12'hB81,
    // Host link for test harnesses
    CSR_MTOHOST   = 12'h780,
    CSR_MFROMHOST = 12'h781
  } csr_addr_t;

  // Pipeline CSR request
  typedef enum logic [1:0] {
    CSR_NONE = 2'b00,
    CSR_SWAP = 2'b01,
    CSR_SET  = 2'b10,
    CSR_CLR  = 2'b11
  } csr_op_t;

  // Exception codes written to mcause
  typedef enum logic [30:0] {
    CAUSE_FETCH_MISALIGNED = 31'd0,
    CAUSE_ILLEGAL_INSN     = 31'd2,
    CAUSE_BREAKPOINT       = 31'd3,
    CAUSE_LOAD_FAULT       = 31'd5,
    CAUSE_STORE_FAULT      = 31'd7,
    CAUSE_ECALL_M          = 31'd11
  } cause_t;

  // Trap controller states
  typedef enum logic {
    RUN       = 1'b0,
    TRAP_HOLD = 1'b1
  } prv_state_t;

  typedef struct packed {
    logic       sd;
    logic [8:0] zero;
    logic [4:0] vm;
    logic       mprv;
    logic [1:0] xs;
    logic [1:0] fs;
    logic [1:0] prv3;
    logic       ie3;
    logic [1:0] prv2;
    logic       ie2;
    logic [1:0] prv1;
    logic       ie1;
    logic [1:0] prv;
    logic       ie;
  } mstatus_t;

  typedef struct packed {
    logic [23:0] zero_2;
    logic        mtie;
    logic        htie;
    logic        stie;
    logic        zero_1;
    logic        msie;
    logic        hsie;
    logic        ssie;
    logic        zero_0;
  } mie_t;

  typedef struct packed {
    logic [23:0] zero_2;
    logic        mtip;
    logic        htip;
    logic        stip;
    logic        zero_1;
    logic        msip;
    logic        hsip;
    logic        ssip;
    logic        zero_0;
  } mip_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] code;
  } mcause_t;

  typedef struct packed {
    logic [1:0]  base;
    logic [3:0]  zero;
    logic [25:0] extensions;
  } mcpuid_t;

endpackage

//--- design/priv_unit.sv
// Top of the machine-mode privilege unit, joins the CSR file and trap controller
`timescale 1ns/1ps

module priv_unit (
  input  logic                            CLK,
  input  logic                            nRST,
  // CSR access from the pipeline
  input  logic [11:0]                     csr_addr,
  input  machine_mode_types_pkg::csr_op_t csr_op,
  input  machine_mode_types_pkg::word_t   csr_wdata,
  output machine_mode_types_pkg::word_t   csr_rdata,
  output logic                            invalid_csr,
  // Trap sources
  input  logic                            fetch_misaligned,
  input  logic                            illegal_insn,
  input  logic                            breakpoint,
  input  logic                            ecall,
  input  logic                            load_fault,
  input  logic                            store_fault,
  input  logic                            mret,
  input  logic                            soft_int,
  input  machine_mode_types_pkg::word_t   epc,
  input  machine_mode_types_pkg::word_t   badaddr,
  // Host link
  input  logic                            fromhost_we,
  input  machine_mode_types_pkg::word_t   fromhost_data,
  // Redirect and host output
  output logic                            trap,
  output machine_mode_types_pkg::word_t   trap_pc,
  output machine_mode_types_pkg::word_t   tohost
);
  import machine_mode_types_pkg::*;

  prv_pipeline_if pipe_if ();
  csr_prv_if      prv_if ();

  // Pipeline side of the CSR channel
  assign pipe_if.addr  = csr_addr_t'(csr_addr);
  assign pipe_if.op    = csr_op;
  assign pipe_if.wdata = csr_wdata;
  assign csr_rdata     = pipe_if.rdata;
  assign invalid_csr   = pipe_if.invalid_csr;

  csr_rfile u_csr (
    .CLK           (CLK),
    .nRST          (nRST),
    .pipe          (pipe_if.csr),
    .prv           (prv_if.csr),
    .fromhost_we   (fromhost_we),
    .fromhost_data (fromhost_data),
    .tohost        (tohost)
  );

  // Bad CSR address counts as an illegal instruction
  prv_control u_prv (
    .CLK              (CLK),
    .nRST             (nRST),
    .prv              (prv_if.prv),
    .epc              (epc),
    .badaddr          (badaddr),
    .fetch_misaligned (fetch_misaligned),
    .illegal_insn     (illegal_insn),
    .breakpoint       (breakpoint),
    .ecall            (ecall),
    .load_fault       (load_fault),
    .store_fault      (store_fault),
    .mret             (mret),
    .soft_int         (soft_int),
    .invalid_csr      (pipe_if.invalid_csr),
    .trap             (trap),
    .trap_pc          (trap_pc)
  );

endmodule

//--- design/prv_consts.svh
// Fixed machine-mode constants, included by the CSR file and the trap controller
`ifndef PRV_CONSTS_SVH
`define PRV_CONSTS_SVH

// Trap vector, hardwired since mtvec is read only
`define MTVEC_ADDR 32'h0000_0100

// Software interrupt position, shared by mip.msip and mie.msie
`define MSIP_BIT 3

// Interrupt flag in mcause
`define MCAUSE_INT_BIT 31

// mcpuid base field, 2'b00 selects RV32
`define MCPUID_BASE_RV32 2'b00

// mcpuid extension bits, only I ('I' - 'A' = bit 8)
`define MCPUID_EXT_I 26'h000_0100

// Privilege encoding for machine mode
`define PRV_MODE_M 2'b11

`endif

//--- design/prv_control.sv
// Trap controller in priv_unit that ranks traps and drives the CSR updates and redirect PC
`timescale 1ns/1ps
`include "prv_consts.svh"

module prv_control (
  input  logic                          CLK,
  input  logic                          nRST,
  csr_prv_if.prv                        prv,
  input  machine_mode_types_pkg::word_t epc,
  input  machine_mode_types_pkg::word_t badaddr,
  input  logic                          fetch_misaligned,
  input  logic                          illegal_insn,
  input  logic                          breakpoint,
  input  logic                          ecall,
  input  logic                          load_fault,
  input  logic                          store_fault,
  input  logic                          mret,
  input  logic                          soft_int,
  input  logic                          invalid_csr,
  output logic                          trap,
  output machine_mode_types_pkg::word_t trap_pc
);
  import machine_mode_types_pkg::*;

  prv_state_t state;
  prv_state_t state_next;

  logic    int_take;
  logic    exc_valid;
  logic    exc_take;
  logic    exc_bad;
  logic    ret_take;
  cause_t  exc_cause;
  mcause_t exc_word;

  // Software interrupt needs global enable, local enable and pending bit
  assign int_take = prv.mstatus.ie & prv.mie.msie & prv.mip.msip;

  // Exception ranking where the first match wins
  always_comb begin
    exc_valid = 1'b1;
    exc_bad   = 1'b0;
    exc_cause = CAUSE_FETCH_MISALIGNED;
    if (fetch_misaligned) begin
      exc_bad = 1'b1;
    end else if (illegal_insn || invalid_csr) begin
      exc_cause = CAUSE_ILLEGAL_INSN;
    end else if (breakpoint) begin
      exc_cause = CAUSE_BREAKPOINT;
    end else if (ecall) begin
      exc_cause = CAUSE_ECALL_M;
    end else if (load_fault) begin
      exc_cause = CAUSE_LOAD_FAULT;
      exc_bad   = 1'b1;
    end else if (store_fault) begin
      exc_cause = CAUSE_STORE_FAULT;
      exc_bad   = 1'b1;
    end else begin
      exc_valid = 1'b0;
    end
  end

  // Exceptions are dropped during hold while the pipeline flushes
  assign exc_take = exc_valid & (state == RUN) & ~int_take;
  assign trap     = int_take | exc_take;
  // A trap in the same cycle supersedes mret
  assign ret_take = mret & ~trap;

  assign trap_pc = ret_take ? prv.mepc : prv.mtvec;

  assign exc_word.interrupt = 1'b0;
  assign exc_word.code      = exc_cause;

  // Trap clears ie and mret sets it
  assign prv.mstatus_ie_rup  = trap | ret_take;
  assign prv.mstatus_ie_next = ~trap;

  // New request keeps msip pending even while one is taken
  assign prv.mip_msip_rup  = soft_int | int_take;
  assign prv.mip_msip_next = soft_int;

  // Interrupt code is zero with only the flag set
  assign prv.mcause_rup  = trap;
  assign prv.mcause_next = int_take ? mcause_t'(32'h1 << `MCAUSE_INT_BIT) : exc_word;

  assign prv.mepc_rup  = trap;
  assign prv.mepc_next = epc;

  // Faulting address only for the three address faults
  assign prv.mbadaddr_rup  = exc_take & exc_bad;
  assign prv.mbadaddr_next = badaddr;

  // One hold cycle after each trap
  assign state_next = trap ? TRAP_HOLD : RUN;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= RUN;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- design/prv_pipeline_if.sv
// CSR access channel between the pipeline side and the machine CSR file
`timescale 1ns/1ps

interface prv_pipeline_if;
  import machine_mode_types_pkg::*;

  // Request from the pipeline
  csr_addr_t addr;
  csr_op_t   op;
  word_t     wdata;

  // Combinational response, same cycle as the request
  word_t     rdata;
  logic      invalid_csr;

  // Pipeline side
  modport pipe (
    output addr,
    output op,
    output wdata,
    input  rdata,
    input  invalid_csr
  );

  // CSR file side
  modport csr (
    input  addr,
    input  op,
    input  wdata,
    output rdata,
    output invalid_csr
  );

endinterface

//--- filelist.f
+incdir+design
design/machine_mode_types_pkg.sv
design/prv_pipeline_if.sv
design/csr_prv_if.sv
design/csr_rfile.sv
design/prv_control.sv
design/priv_unit.sv
test/tb_priv_unit.sv

//--- test/priv_testdata.txt
// addr op wdata flags epc badaddr fh_data | rdata invalid trap trap_pc tohost mask, all hex
// flags 001 fetch 002 illegal 004 brk 008 ecall 010 load 020 store 040 mret 080 sint 100 fh_we
// reset values
300 0 00000000 000 00000000 00000000 00000000 00000db7 0 0 00000100 00000000 1f
301 0 00000000 000 00000000 00000000 00000000 00000100 0 0 00000100 00000000 1f
f00 0 00000000 000 00000000 00000000 00000000 00000100 0 0 00000100 00000000 1f
341 0 00000000 000 00000000 00000000 00000000 00000000 0 0 00000100 00000000 1f
342 0 00000000 000 00000000 00000000 00000000 00000000 0 0 00000100 00000000 1f
// swap, set, clear on mscratch and mie
340 1 a5a5f00f 000 00000000 00000000 00000000 00000000 0 0 00000100 00000000 1f
340 2 0000fff0 000 00000000 00000000 00000000 a5a5f00f 0 0 00000100 00000000 1f
340 3 ff00000f 000 00000000 00000000 00000000 a5a5ffff 0 0 00000100 00000000 1f
340 0 00000000 000 00000000 00000000 00000000 00a5fff0 0 0 00000100 00000000 1f
304 1 ffffffff 000 00000000 00000000 00000000 00000000 0 0 00000100 00000000 1f
304 3 00000008 000 00000000 00000000 00000000 00000008 0 0 00000100 00000000 1f
304 2 00000008 000 00000000 00000000 00000000 00000000 0 0 00000100 00000000 1f
// address check, bad address traps as illegal
7c0 2 00000000 000 00000200 00000000 00000000 00000000 1 1 00000100 00000000 1f
701 2 00000000 000 00000000 00000000 00000000 00000000 0 0 00000100 00000000 1f
f00 1 ffffffff 000 00000000 00000000 00000000 00000100 0 0 00000100 00000000 1f
f00 0 00000000 000 00000000 00000000 00000000 00000100 0 0 00000100 00000000 1f
342 0 00000000 000 00000000 00000000 00000000 00000002 0 0 00000100 00000000 1f
300 0 00000000 040 00000000 00000000 00000000 00000db6 0 0 00000200 00000000 1f
300 0 00000000 000 00000000 00000000 00000000 00000db7 0 0 00000100 00000000 1f
// single exceptions, each followed by its hold cycle
342 0 00000000 001 00001000 00001002 00000000 00000002 0 1 00000100 00000000 1f
343 0 00000000 000 00000000 00000000 00000000 00001002 0 0 00000100 00000000 1f
342 0 00000000 002 00001004 deadbeef 00000000 00000000 0 1 00000100 00000000 1f
343 0 00000000 000 00000000 00000000 00000000 00001002 0 0 00000100 00000000 1f
342 0 00000000 004 00001008 deadbeef 00000000 00000002 0 1 00000100 00000000 1f
341 0 00000000 000 00000000 00000000 00000000 00001008 0 0 00000100 00000000 1f
342 0 00000000 008 0000100c deadbeef 00000000 00000003 0 1 00000100 00000000 1f
342 0 00000000 000 00000000 00000000 00000000 0000000b 0 0 00000100 00000000 1f
343 0 00000000 010 00001010 00002000 00000000 00001002 0 1 00000100 00000000 1f
342 0 00000000 000 00000000 00000000 00000000 00000005 0 0 00000100 00000000 1f
343 0 00000000 020 00001014 00003000 00000000 00002000 0 1 00000100 00000000 1f
342 0 00000000 000 00000000 00000000 00000000 00000007 0 0 00000100 00000000 1f
// pairs, and a breakpoint dropped during hold
343 0 00000000 021 00001018 00004000 00000000 00003000 0 1 00000100 00000000 1f
342 0 00000000 004 0000101a 00009999 00000000 00000000 0 0 00000100 00000000 1f
342 0 00000000 00a 0000101c 00005000 00000000 00000000 0 1 00000100 00000000 1f
342 0 00000000 000 00000000 00000000 00000000 00000002 0 0 00000100 00000000 1f
343 0 00000000 014 00001020 00006000 00000000 00004000 0 1 00000100 00000000 1f
343 0 00000000 000 00000000 00000000 00000000 00004000 0 0 00000100 00000000 1f
342 0 00000000 018 00001024 00007000 00000000 00000003 0 1 00000100 00000000 1f
342 0 00000000 000 00000000 00000000 00000000 0000000b 0 0 00000100 00000000 1f
343 0 00000000 030 00001028 00008000 00000000 00004000 0 1 00000100 00000000 1f
342 0 00000000 000 00000000 00000000 00000000 00000005 0 0 00000100 00000000 1f
343 0 00000000 040 00000000 00000000 00000000 00008000 0 0 00001028 00000000 1f
// software interrupt gating, trap and mret
304 3 00000008 000 00000000 00000000 00000000 00000008 0 0 00000100 00000000 1f
344 0 00000000 080 00000000 00000000 00000000 00000000 0 0 00000100 00000000 1f
344 0 00000000 000 00000000 00000000 00000000 00000008 0 0 00000100 00000000 1f
304 2 00000008 000 00000000 00000000 00000000 00000000 0 0 00000100 00000000 1f
342 0 00000000 000 00002000 00000000 00000000 00000005 0 1 00000100 00000000 1f
342 0 00000000 000 00000000 00000000 00000000 80000000 0 0 00000100 00000000 1f
344 0 00000000 000 00000000 00000000 00000000 00000000 0 0 00000100 00000000 1f
300 0 00000000 040 00000000 00000000 00000000 00000db6 0 0 00002000 00000000 1f
300 0 00000000 000 00000000 00000000 00000000 00000db7 0 0 00000100 00000000 1f
// host registers
780 1 cafef00d 000 00000000 00000000 00000000 00000000 0 0 00000100 00000000 1f
780 0 00000000 000 00000000 00000000 00000000 cafef00d 0 0 00000100 cafef00d 1f
781 0 00000000 100 00000000 00000000 12345678 00000000 0 0 00000100 cafef00d 1f
781 0 00000000 000 00000000 00000000 00000000 12345678 0 0 00000100 cafef00d 1f

//--- test/tb_priv_unit.sv
// Vector-driven testbench for priv_unit, applies test/priv_testdata.txt one line per cycle
`timescale 1ns/1ps

module tb_priv_unit;
  import machine_mode_types_pkg::*;

  localparam int    CLK_PERIOD   = 8;
  // Sample 1 ns ahead of the rising edge, inputs settled and state not yet updated
  localparam int    SAMPLE_DELAY = CLK_PERIOD / 2 - 1;
  localparam int    RESET_CYCLES = 4;
  localparam int    NUM_COLS     = 13;
  localparam string DATA_FILE    = "test/priv_testdata.txt";

  // One cycle of stimulus and the outputs expected in that cycle
  typedef struct packed {
    logic [11:0] addr;
    logic [1:0]  op;
    logic [31:0] wdata;
    logic [8:0]  flags;
    logic [31:0] epc;
    logic [31:0] badaddr;
    logic [31:0] fh_data;
    logic [31:0] exp_rdata;
    logic        exp_invalid;
    logic        exp_trap;
    logic [31:0] exp_trap_pc;
    logic [31:0] exp_tohost;
    logic [4:0]  mask;
  } vector_t;

  logic        CLK;
  logic        nRST;
  logic [11:0] csr_addr;
  csr_op_t     csr_op;
  word_t       csr_wdata;
  word_t       csr_rdata;
  logic        invalid_csr;
  logic        fetch_misaligned;
  logic        illegal_insn;
  logic        breakpoint;
  logic        ecall;
  logic        load_fault;
  logic        store_fault;
  logic        mret;
  logic        soft_int;
  word_t       epc;
  word_t       badaddr;
  logic        fromhost_we;
  word_t       fromhost_data;
  logic        trap;
  word_t       trap_pc;
  word_t       tohost;

  vector_t vectors[$];
  int      value_errors;
  int      other_errors;
  int      applied;
  logic    loaded;

  priv_unit UUT (
    .CLK              (CLK),
    .nRST             (nRST),
    .csr_addr         (csr_addr),
    .csr_op           (csr_op),
    .csr_wdata        (csr_wdata),
    .csr_rdata        (csr_rdata),
    .invalid_csr      (invalid_csr),
    .fetch_misaligned (fetch_misaligned),
    .illegal_insn     (illegal_insn),
    .breakpoint       (breakpoint),
    .ecall            (ecall),
    .load_fault       (load_fault),
    .store_fault      (store_fault),
    .mret             (mret),
    .soft_int         (soft_int),
    .epc              (epc),
    .badaddr          (badaddr),
    .fromhost_we      (fromhost_we),
    .fromhost_data    (fromhost_data),
    .trap             (trap),
    .trap_pc          (trap_pc),
    .tohost           (tohost)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Idle bus, no trap sources, reset held
  task automatic init_signals();
    nRST             = 1'b0;
    csr_addr         = '0;
    csr_op           = CSR_NONE;
    csr_wdata        = '0;
    fetch_misaligned = 1'b0;
    illegal_insn     = 1'b0;
    breakpoint       = 1'b0;
    ecall            = 1'b0;
    load_fault       = 1'b0;
    store_fault      = 1'b0;
    mret             = 1'b0;
    soft_int         = 1'b0;
    epc              = '0;
    badaddr          = '0;
    fromhost_we      = 1'b0;
    fromhost_data    = '0;
    value_errors     = 0;
    other_errors     = 0;
    applied          = 0;
    loaded           = 1'b0;
  endtask

  // Lines starting with a slash or empty lines are skipped
  task automatic load_vectors();
    integer      fd;
    integer      n;
    integer      line_no;
    string       line;
    logic [31:0] col [0:NUM_COLS-1];
    vector_t     v;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      other_errors++;
      $display("Cannot open the vector file %s", DATA_FILE);
    end else begin
      line_no = 0;
      while ($fgets(line, fd) > 0) begin
        line_no++;
        if (line.len() > 1 && line.getc(0) != "/") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                      col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                      col[7], col[8], col[9], col[10], col[11], col[12]);
          if (n != NUM_COLS || col[0] > 32'hfff || col[1] > 3 || col[3] > 32'h1ff ||
              col[8] > 1 || col[9] > 1 || col[12] > 32'h1f) begin
            other_errors++;
            $display("Line %0d of %s is malformed and was skipped", line_no, DATA_FILE);
          end else begin
            v.addr        = col[0][11:0];
            v.op          = col[1][1:0];
            v.wdata       = col[2];
            v.flags       = col[3][8:0];
            v.epc         = col[4];
            v.badaddr     = col[5];
            v.fh_data     = col[6];
            v.exp_rdata   = col[7];
            v.exp_invalid = col[8][0];
            v.exp_trap    = col[9][0];
            v.exp_trap_pc = col[10];
            v.exp_tohost  = col[11];
            v.mask        = col[12][4:0];
            vectors.push_back(v);
          end
        end
      end
      $fclose(fd);
      if (vectors.size() == 0) begin
        other_errors++;
        $display("The vector file %s holds no vectors", DATA_FILE);
      end
    end
  endtask

  // Flag bits follow the column legend of the data file
  task automatic apply_vector(input vector_t v);
    csr_addr         = v.addr;
    csr_op           = csr_op_t'(v.op);
    csr_wdata        = v.wdata;
    fetch_misaligned = v.flags[0];
    illegal_insn     = v.flags[1];
    breakpoint       = v.flags[2];
    ecall            = v.flags[3];
    load_fault       = v.flags[4];
    store_fault      = v.flags[5];
    mret             = v.flags[6];
    soft_int         = v.flags[7];
    fromhost_we      = v.flags[8];
    epc              = v.epc;
    badaddr          = v.badaddr;
    fromhost_data    = v.fh_data;
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      value_errors++;
      $display("CHECK FAILED at %0d ns: %s expected %08h, got %08h",
               $time, name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      value_errors++;
      $display("CHECK FAILED at %0d ns: %s expected %b, got %b",
               $time, name, expected, actual);
    end
  endtask

  // Mask bits 4..0 select rdata, invalid_csr, trap, trap_pc, tohost
  task automatic check_outputs(input vector_t v);
    if (v.mask[4]) check_word("csr_rdata", v.exp_rdata, csr_rdata);
    if (v.mask[3]) check_bit("invalid_csr", v.exp_invalid, invalid_csr);
    if (v.mask[2]) check_bit("trap", v.exp_trap, trap);
    if (v.mask[1]) check_word("trap_pc", v.exp_trap_pc, trap_pc);
    if (v.mask[0]) check_word("tohost", v.exp_tohost, tohost);
  endtask

  task automatic report_and_finish();
    $display("Errors: %0d value mismatches, %0d other failures, %0d of %0d vectors applied",
             value_errors, other_errors, applied, vectors.size());
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  initial begin
    init_signals();
    load_vectors();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    foreach (vectors[i]) begin
      apply_vector(vectors[i]);
      #(SAMPLE_DELAY);
      check_outputs(vectors[i]);
      applied++;
      @(negedge CLK);
    end
    report_and_finish();
  end

  // Budget of one period per vector plus slack for reset
  initial begin
    wait (loaded);
    #(CLK_PERIOD * (vectors.size() + 20));
    other_errors++;
    $display("Timeout: run did not complete within %0d cycles", vectors.size() + 20);
    report_and_finish();
  end

endmodule
